// File: Makefile
TOP       ?= tbHazard
FLIST     ?= vlog.f
LOG       ?= sim.log
OBJDIR    ?= obj_dir
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert --timing
SIMFLAGS  ?= +verilator+error+limit+1000

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJDIR)

run: build
	@./$(OBJDIR)/V$(TOP) $(SIMFLAGS) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "tests failed" $(LOG); then \
		echo "Simulation FAILED, see $(LOG)"; \
		exit 1; \
	else \
		echo "Simulation passed"; \
	fi

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: common/hazardCtrlPkg.sv
`include "hazard_defines.svh"

package hazardCtrlPkg;

	typedef logic [`FWD_SEL_W-1:0] fwdSelT;

	// Bypass controls, 6 bits
	typedef struct packed {
		fwdSelT exRsSel;
		fwdSelT exRtSel;
		logic idRsMem; // Branch rs from MEM
		logic idRtMem; // Branch rt from MEM
	} fwdCtrlT;

	// Front end controls, 4 bits
	typedef struct packed {
		logic instReqEn;
		logic pcWr;
		logic ifIdWr;
		logic idExBubble;
	} fetchCtrlT;

	// Data cache wait machine
	typedef enum logic {
		dcFree = 1'b0,
		dcBusy = 1'b1
	} dcacheStateT;

endpackage

// File: common/hazard_defines.svh
`ifndef HAZARD_DEFINES_SVH
`define HAZARD_DEFINES_SVH

// Register file has 32 entries
`define REG_ADDR_W 5

// Byte address of an instruction
`define PC_W 32

// EX operand bypass select
`define FWD_SEL_W 2

`define FWD_NONE 2'd0 // Register file value
`define FWD_MEM  2'd1 // Result sitting in MEM
`define FWD_WB   2'd2 // Result sitting in WB

`endif

// File: common/pipeStagePkg.sv
`include "hazard_defines.svh"

package pipeStagePkg;

	typedef logic [`REG_ADDR_W-1:0] regAddrT;
	typedef logic [`PC_W-1:0] pcT;

	// Decode stage view, 43 bits
	typedef struct packed {
		regAddrT rs;
		regAddrT rt;
		pcT pc;
		logic bjOp; // Branch or jump compared in ID
	} idStageT;

	// Execute stage view, 45 bits
	typedef struct packed {
		regAddrT rs;
		regAddrT rt;
		pcT pc;
		logic rfWr;
		logic dmRd; // Load
		logic cp0Rd; // mfc0
	} exStageT;

	// Memory stage view, 16 bits
	typedef struct packed {
		regAddrT rd;
		regAddrT rt;
		logic rfWr;
		logic dmRd;
		logic cp0Rd;
		logic excValid; // Exception taken here
		logic eretFlush;
		logic dCacheEn; // Data access issued
	} memStageT;

	// Writeback stage view, 6 bits
	typedef struct packed {
		regAddrT rd;
		logic rfWr;
	} wbStageT;

endpackage

// File: hazard/forwardUnit.sv
`include "hazard_defines.svh"

module forwardUnit (
	input pipeStagePkg::idStageT idStage,
	input pipeStagePkg::exStageT exStage,
	input pipeStagePkg::memStageT memStage,
	input pipeStagePkg::wbStageT wbStage,
	output hazardCtrlPkg::fwdCtrlT fwdCtrl
);

	import pipeStagePkg::*;
	import hazardCtrlPkg::*;

	// MEM holds a live result for src
	function automatic logic memHit(
		input regAddrT src,
		input memStageT mem
	);
		logic hit;
		hit = mem.rfWr && (mem.rd != '0) && (mem.rd == src);
		return hit;
	endfunction

	// WB holds a live result for src
	function automatic logic wbHit(
		input regAddrT src,
		input wbStageT wb
	);
		logic hit;
		hit = wb.rfWr && (wb.rd != '0) && (wb.rd == src);
		return hit;
	endfunction

	// Younger producer wins
	function automatic fwdSelT exSel(
		input regAddrT src,
		input memStageT mem,
		input wbStageT wb
	);
		fwdSelT sel;
		if (memHit(src, mem)) begin
			sel = `FWD_MEM;
		end else if (wbHit(src, wb)) begin
			sel = `FWD_WB;
		end else begin
			sel = `FWD_NONE;
		end
		return sel;
	endfunction

	fwdSelT exRsSel;
	fwdSelT exRtSel;
	logic idRsMem;
	logic idRtMem;

	always_comb begin
		exRsSel = exSel(exStage.rs, memStage, wbStage);
		exRtSel = exSel(exStage.rt, memStage, wbStage);
	end

	// Compare in ID only sees MEM results
	always_comb begin
		idRsMem = idStage.bjOp && memHit(idStage.rs, memStage);
		idRtMem = idStage.bjOp && memHit(idStage.rt, memStage);
	end

	always_comb begin
		fwdCtrl.exRsSel = exRsSel;
		fwdCtrl.exRtSel = exRtSel;
		fwdCtrl.idRsMem = idRsMem;
		fwdCtrl.idRtMem = idRtMem;
	end

endmodule

// File: hazard/hazardUnit.sv
`include "hazard_defines.svh"

module hazardUnit (
	input logic clk,
	input logic rst,
	input pipeStagePkg::idStageT idStage,
	input pipeStagePkg::exStageT exStage,
	input pipeStagePkg::memStageT memStage,
	input pipeStagePkg::wbStageT wbStage,
	input logic bootHold,
	input logic mduBusy,
	input logic hiLoAccess,
	input logic iCacheDataOk,
	input logic dCacheDataOk,
	output hazardCtrlPkg::fwdCtrlT fwdCtrl,
	output hazardCtrlPkg::fetchCtrlT fetchCtrl,
	output logic dcacheStall
);

	// Bypass selects for EX and branch compare
	forwardUnit u_forward (
		.idStage(idStage),
		.exStage(exStage),
		.memStage(memStage),
		.wbStage(wbStage),
		.fwdCtrl(fwdCtrl)
	);

	// Front end hold and data cache wait
	stallUnit u_stall (
		.clk(clk),
		.rst(rst),
		.idStage(idStage),
		.exStage(exStage),
		.memStage(memStage),
		.bootHold(bootHold),
		.mduBusy(mduBusy),
		.hiLoAccess(hiLoAccess),
		.iCacheDataOk(iCacheDataOk),
		.dCacheDataOk(dCacheDataOk),
		.fetchCtrl(fetchCtrl),
		.dcacheStall(dcacheStall)
	);

endmodule

// File: hazard/stallUnit.sv
module stallUnit (
	input logic clk,
	input logic rst,
	input pipeStagePkg::idStageT idStage,
	input pipeStagePkg::exStageT exStage,
	input pipeStagePkg::memStageT memStage,
	input logic bootHold,
	input logic mduBusy,
	input logic hiLoAccess,
	input logic iCacheDataOk,
	input logic dCacheDataOk,
	output hazardCtrlPkg::fetchCtrlT fetchCtrl,
	output logic dcacheStall
);

	import hazardCtrlPkg::*;

	logic exRtHit;
	logic memRtHit;
	logic samePc;
	logic flushGo;
	logic mduStall;
	logic loadUseStall;
	logic memBranchStall;
	logic exBranchStall;
	logic stall;

	dcacheStateT dcState;
	dcacheStateT dcNext;

	// Register matches against the ID sources
	always_comb begin
		exRtHit = (exStage.rt == idStage.rs) || (exStage.rt == idStage.rt);
		memRtHit = (memStage.rt == idStage.rs) || (memStage.rt == idStage.rt);
		samePc = (idStage.pc == exStage.pc);
	end

	always_comb begin
		flushGo = memStage.excValid || memStage.eretFlush;
		mduStall = mduBusy && hiLoAccess; // HI/LO not ready yet
	end

	// Result of a load or mfc0 arrives too late for EX bypass
	always_comb begin
		loadUseStall = (exStage.dmRd || exStage.cp0Rd) && exRtHit && !samePc;
	end

	// Branch compares in ID, so operands must already exist
	always_comb begin
		memBranchStall = idStage.bjOp && memStage.rfWr
			&& (memStage.dmRd || memStage.cp0Rd) && memRtHit;
		exBranchStall = idStage.bjOp && exStage.rfWr && exRtHit;
	end

	// Priority chain
	always_comb begin
		if (bootHold) begin
			stall = 1'b1;
		end else if (!iCacheDataOk) begin
			stall = 1'b1; // Fetch still outstanding
		end else if (flushGo) begin
			stall = 1'b0; // Redirect to handler or EPC
		end else if (mduStall) begin
			stall = 1'b1;
		end else if (loadUseStall) begin
			stall = 1'b1;
		end else if (memBranchStall) begin
			stall = 1'b1;
		end else if (exBranchStall) begin
			stall = 1'b1;
		end else begin
			stall = 1'b0;
		end
	end

	always_comb begin
		fetchCtrl.instReqEn = !stall;
		fetchCtrl.pcWr = !stall;
		fetchCtrl.ifIdWr = !stall;
		fetchCtrl.idExBubble = stall;
	end

	always_comb begin
		dcNext = dcState;
		case (dcState)
			dcFree: begin
				if (memStage.dCacheEn && !dCacheDataOk) begin
					dcNext = dcBusy; // Miss or slow access
				end
			end
			dcBusy: begin
				if (dCacheDataOk) begin
					dcNext = dcFree;
				end
			end
			default: begin
				dcNext = dcFree;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			dcState <= dcFree;
		end else begin
			dcState <= dcNext;
		end
	end

	assign dcacheStall = (dcState == dcBusy);

endmodule

// File: tb/hazard_asserts.sv
`include "hazard_defines.svh"

module hazardAsserts (
	input logic clk,
	input logic rst,
	input pipeStagePkg::idStageT idStage,
	input pipeStagePkg::exStageT exStage,
	input pipeStagePkg::memStageT memStage,
	input pipeStagePkg::wbStageT wbStage,
	input logic bootHold,
	input logic mduBusy,
	input logic hiLoAccess,
	input logic iCacheDataOk,
	input logic dCacheDataOk,
	input hazardCtrlPkg::fwdCtrlT fwdCtrl,
	input hazardCtrlPkg::fetchCtrlT fetchCtrl,
	input logic dcacheStall
);

	import hazardCtrlPkg::*;

	int errCount = 0;
	fwdSelT rsExp;
	fwdSelT rtExp;
	logic [1:0] idExp;
	logic exHit;
	logic memHit;
	logic lowerStall;
	logic stallExp;

	function automatic void countError(input string msg);
		errCount = errCount + 1;
		$error("%s", msg);
	endfunction

	// Reference bypass selects, MEM over WB and r0 excluded
	always_comb begin
		rsExp = (memStage.rfWr && memStage.rd != '0 && memStage.rd == exStage.rs) ? `FWD_MEM
			: (wbStage.rfWr && wbStage.rd != '0 && wbStage.rd == exStage.rs) ? `FWD_WB : `FWD_NONE;
		rtExp = (memStage.rfWr && memStage.rd != '0 && memStage.rd == exStage.rt) ? `FWD_MEM
			: (wbStage.rfWr && wbStage.rd != '0 && wbStage.rd == exStage.rt) ? `FWD_WB : `FWD_NONE;
		idExp[1] = idStage.bjOp && memStage.rfWr && memStage.rd != '0 && memStage.rd == idStage.rs;
		idExp[0] = idStage.bjOp && memStage.rfWr && memStage.rd != '0 && memStage.rd == idStage.rt;
	end

	always_comb begin
		exHit = (exStage.rt == idStage.rs) || (exStage.rt == idStage.rt);
		memHit = (memStage.rt == idStage.rs) || (memStage.rt == idStage.rt);
		lowerStall = (mduBusy && hiLoAccess)
			|| ((exStage.dmRd || exStage.cp0Rd) && exHit && idStage.pc != exStage.pc)
			|| (idStage.bjOp && memStage.rfWr && (memStage.dmRd || memStage.cp0Rd) && memHit)
			|| (idStage.bjOp && exStage.rfWr && exHit);
		stallExp = bootHold || !iCacheDataOk
			|| (!memStage.excValid && !memStage.eretFlush && lowerStall); // Flush beats lower causes
	end

	exFwdCheck: assert property (@(posedge clk) {fwdCtrl.exRsSel, fwdCtrl.exRtSel} == {rsExp, rtExp})
		else countError($sformatf("CHECK FAILED exForward expected %h actual %h",
			$sampled({rsExp, rtExp}), $sampled({fwdCtrl.exRsSel, fwdCtrl.exRtSel})));
	idFwdCheck: assert property (@(posedge clk) {fwdCtrl.idRsMem, fwdCtrl.idRtMem} == idExp)
		else countError($sformatf("CHECK FAILED idForward expected %b actual %b",
			$sampled(idExp), $sampled({fwdCtrl.idRsMem, fwdCtrl.idRtMem})));
	fetchCheck: assert property (@(posedge clk)
		fetchCtrl == {!stallExp, !stallExp, !stallExp, stallExp})
		else countError($sformatf("CHECK FAILED fetchCtrl expected %b actual %b",
			$sampled({!stallExp, !stallExp, !stallExp, stallExp}), $sampled(fetchCtrl)));
	dcResetCheck: assert property (@(posedge clk) !rst |=> !dcacheStall)
		else countError("CHECK FAILED dcacheReset expected 0 actual 1");
	dcFreeCheck: assert property (@(posedge clk)
		rst && !dcacheStall |=> dcacheStall == $past(memStage.dCacheEn && !dCacheDataOk))
		else countError($sformatf("CHECK FAILED dcacheFree expected %0b actual %0b",
			!$sampled(dcacheStall), $sampled(dcacheStall)));
	dcBusyCheck: assert property (@(posedge clk)
		rst && dcacheStall |=> dcacheStall == $past(!dCacheDataOk)) // Held until data returns
		else countError($sformatf("CHECK FAILED dcacheBusy expected %0b actual %0b",
			!$sampled(dcacheStall), $sampled(dcacheStall)));

endmodule

bind hazardUnit hazardAsserts u_asserts (.*);

// File: tb/tbHazard.sv
module tbHazard;

	import pipeStagePkg::*;
	import hazardCtrlPkg::*;

	logic clk;
	logic rst;
	idStageT idStage;
	exStageT exStage;
	memStageT memStage;
	wbStageT wbStage;
	logic bootHold;
	logic mduBusy;
	logic hiLoAccess;
	logic iCacheDataOk;
	logic dCacheDataOk;
	fwdCtrlT fwdCtrl;
	fetchCtrlT fetchCtrl;
	logic dcacheStall;
	integer seed;
	int timeouts;
	int unreached;
	logic [12:0] reached;

	hazardUnit u_dut (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Small range so register matches are frequent
	function automatic regAddrT regNum();
		return regAddrT'($random(seed) & 3);
	endfunction

	function automatic logic rareBit(input int mask);
		return ($random(seed) & mask) == 0;
	endfunction

	task automatic randomCycle();
		@(posedge clk);
		idStage <= '{rs: regNum(), rt: regNum(), pc: pcT'($random(seed) & 1), bjOp: rareBit(1)};
		exStage <= '{rs: regNum(), rt: regNum(), pc: pcT'($random(seed) & 1),
			rfWr: rareBit(1), dmRd: rareBit(3), cp0Rd: rareBit(3)};
		memStage <= '{rd: regNum(), rt: regNum(), rfWr: rareBit(1), dmRd: rareBit(3),
			cp0Rd: rareBit(3), excValid: rareBit(7), eretFlush: rareBit(7), dCacheEn: rareBit(3)};
		wbStage <= '{rd: regNum(), rfWr: rareBit(1)};
		bootHold <= rareBit(15);
		mduBusy <= rareBit(1);
		hiLoAccess <= rareBit(3);
		iCacheDataOk <= !rareBit(7);
		dCacheDataOk <= rareBit(1);
	endtask

	// Flush with every lower stall cause present
	task automatic priorityCase(input logic hold, input logic icOk);
		@(posedge clk);
		idStage <= '{rs: 5'd3, rt: 5'd1, pc: 32'h40, bjOp: 1'b1};
		exStage <= '{rs: 5'd2, rt: 5'd3, pc: 32'h3c, rfWr: 1'b1, dmRd: 1'b1, cp0Rd: 1'b0};
		memStage <= '{rd: 5'd3, rt: 5'd1, rfWr: 1'b1, dmRd: 1'b1, cp0Rd: 1'b0,
			excValid: 1'b1, eretFlush: !hold, dCacheEn: 1'b0};
		wbStage <= '{rd: 5'd3, rfWr: 1'b1}; // Same rd as MEM
		bootHold <= hold;
		iCacheDataOk <= icOk;
		mduBusy <= 1'b1;
		hiLoAccess <= 1'b1;
	endtask

	task automatic waitStall(input logic level);
		int n;
		n = 0;
		@(negedge clk);
		while (dcacheStall !== level && n < 20) begin
			@(negedge clk);
			n++;
		end
		if (dcacheStall !== level) begin
			timeouts++;
			$display("Timeout waiting for dcacheStall to reach %0b", level);
		end
	endtask

	task automatic dcacheAccess(input int busyCycles);
		@(posedge clk);
		memStage.dCacheEn <= 1'b0;
		dCacheDataOk <= 1'b1;
		waitStall(1'b0);
		@(posedge clk);
		memStage.dCacheEn <= 1'b1;
		dCacheDataOk <= 1'b0;
		waitStall(1'b1);
		repeat (busyCycles + 1) @(posedge clk);
		memStage.dCacheEn <= 1'b0;
		dCacheDataOk <= 1'b1;
		waitStall(1'b0);
	endtask

	always @(posedge clk) begin
		if (rst) begin
			reached <= reached | {
				!bootHold && iCacheDataOk && !memStage.excValid && !memStage.eretFlush
					&& mduBusy && hiLoAccess,
				idStage.bjOp && memStage.rfWr && memStage.dmRd && (memStage.rt == idStage.rt),
				exStage.cp0Rd && (exStage.rt == idStage.rt) && (exStage.pc != idStage.pc),
				wbStage.rfWr && (wbStage.rd != '0) && (wbStage.rd == exStage.rt)
					&& !(memStage.rfWr && (memStage.rd == exStage.rt)),
				memStage.dCacheEn && !dCacheDataOk,
				!bootHold && iCacheDataOk && memStage.excValid && mduBusy && hiLoAccess,
				(bootHold || !iCacheDataOk) && (memStage.excValid || memStage.eretFlush),
				idStage.bjOp && exStage.rfWr && (exStage.rt == idStage.rs),
				exStage.dmRd && (exStage.rt == idStage.rs) && (exStage.pc == idStage.pc),
				exStage.dmRd && (exStage.rt == idStage.rs) && (exStage.pc != idStage.pc),
				idStage.bjOp && memStage.rfWr && (memStage.rd != '0) && (memStage.rd == idStage.rs),
				memStage.rfWr && (memStage.rd == '0) && (exStage.rs == '0),
				memStage.rfWr && wbStage.rfWr && (memStage.rd != '0)
					&& (memStage.rd == wbStage.rd) && (memStage.rd == exStage.rs)
			};
		end
	end

	initial begin
		seed = 75153;
		timeouts = 0;
		unreached = 0;
		reached = '0;
		rst = 1'b0;
		idStage = '0;
		exStage = '0;
		memStage = '0;
		wbStage = '0;
		bootHold = 1'b0;
		mduBusy = 1'b0;
		hiLoAccess = 1'b0;
		iCacheDataOk = 1'b1;
		dCacheDataOk = 1'b1;
		repeat (4) @(posedge clk);
		rst <= 1'b1;
		priorityCase(1'b1, 1'b1);
		priorityCase(1'b0, 1'b0);
		priorityCase(1'b0, 1'b1);
		dcacheAccess(0);
		dcacheAccess(3);
		repeat (400) randomCycle();
		dcacheAccess(5);
		repeat (2) @(posedge clk);
		for (int i = 0; i < 13; i++) begin
			if (!reached[i]) begin
				unreached++;
				$display("Behavior %0d was never exercised by the stimulus", i);
			end
		end
		$display("Errors: unreached %0d, timeouts %0d, assertion failures %0d",
			unreached, timeouts, u_dut.u_asserts.errCount);
		if (unreached == 0 && timeouts == 0 && u_dut.u_asserts.errCount == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// File: vlog.f
+incdir+common
common/pipeStagePkg.sv
common/hazardCtrlPkg.sv
hazard/forwardUnit.sv
hazard/stallUnit.sv
hazard/hazardUnit.sv
tb/hazard_asserts.sv
tb/tbHazard.sv
